/* Bender.yml */
package:
  name: mips_core_backend

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - registers_bank.sv
      - decode_stage.sv
      - execute_stage.sv
      - core_top.sv
      - target: test
        files:
          - tb_core.sv

/* core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register file geometry
`define NB_DATA     32
`define NB_ADDR     5
`define BANK_DEPTH  32

// Instruction field widths
`define NB_OPCODE   6
`define NB_FUNCT    6
`define NB_SHAMT    5
`define NB_IMM      16

// Opcodes, primary field
`define OP_RTYPE    6'h00   // Funct selects the operation
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c   // Zero extended
`define OP_ORI      6'h0d   // Zero extended
`define OP_XORI     6'h0e   // Zero extended
`define OP_LUI      6'h0f

// Funct codes for R-type
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

`endif

/* core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [`NB_OPCODE-1:0] opcode;
        logic [`NB_ADDR-1:0]   rs;
        logic [`NB_ADDR-1:0]   rt;
        logic [`NB_ADDR-1:0]   rd;
        logic [`NB_SHAMT-1:0]  shamt;
        logic [`NB_FUNCT-1:0]  funct;
    } r_fields_t;

    // I-type view of the same word
    typedef struct packed {
        logic [`NB_OPCODE-1:0] opcode;
        logic [`NB_ADDR-1:0]   rs;
        logic [`NB_ADDR-1:0]   rt;
        logic [`NB_IMM-1:0]    imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SRL, SRA,  // Shift amount from shamt
        LUI
    } alu_op_e;

    // Decoded control, registered alongside the operand read
    typedef struct packed {
        logic                  valid;
        logic                  write;
        alu_op_e               alu_op;
        logic                  use_imm;     // Second operand is the immediate
        logic                  imm_signed;  // Sign extend, else zero extend
        logic [`NB_IMM-1:0]    imm;
        logic [`NB_SHAMT-1:0]  shamt;
        logic [`NB_ADDR-1:0]   rs;
        logic [`NB_ADDR-1:0]   rt;
        logic [`NB_ADDR-1:0]   dest;
    } ctrl_t;

    // Execute output, also the bank write port
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`NB_ADDR-1:0]   dest;
        logic [`NB_DATA-1:0]   value;
    } result_t;

endpackage

/* core_top.sv */
`include "core_defines.svh"

module core_top
    import core_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_instr_valid,
    input  instr_t              i_instr,
    input  logic                i_halt,
    input  logic                i_debug_read,
    input  logic [`NB_ADDR-1:0] i_debug_addr,
    output result_t             o_result,
    output logic [`NB_DATA-1:0] o_debug_data
);

    logic [`NB_ADDR-1:0] read_reg_a;
    logic [`NB_ADDR-1:0] read_reg_b;
    logic [`NB_DATA-1:0] data_a;
    logic [`NB_DATA-1:0] data_b;
    logic                bank_enable;
    ctrl_t               ctrl;
    result_t             result;

    assign bank_enable = ~i_halt;

    decode_stage u_decode (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_halt        (i_halt),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_read_reg_a  (read_reg_a),
        .o_read_reg_b  (read_reg_b),
        .o_ctrl        (ctrl)
    );

    // Write port fed back from the execute result register
    registers_bank u_bank (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (bank_enable),
        .i_reg_write    (result.write),
        .i_read_reg_a   (read_reg_a),
        .i_read_reg_b   (read_reg_b),
        .i_write_reg    (result.dest),
        .i_write_data   (result.value),
        .i_read_enable  (i_debug_read),
        .i_read_address (i_debug_addr),
        .o_data_a       (data_a),
        .o_data_b       (data_b)
    );

    execute_stage u_execute (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_ctrl   (ctrl),
        .i_data_a (data_a),
        .i_data_b (data_b),
        .o_result (result)
    );

    assign o_result     = result;
    assign o_debug_data = data_a;  // Port A doubles as debug output

endmodule

/* decode_stage.sv */
`include "core_defines.svh"

module decode_stage
    import core_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_halt,
    input  logic                i_instr_valid,
    input  instr_t              i_instr,
    output logic [`NB_ADDR-1:0] o_read_reg_a,
    output logic [`NB_ADDR-1:0] o_read_reg_b,
    output ctrl_t               o_ctrl
);

    ctrl_t ctrl_dec;

    always_comb begin
        ctrl_dec = '0;
        ctrl_dec.alu_op = ADD;

        // Source registers sit at the same bits in both views
        ctrl_dec.rs = i_instr.r.rs;
        ctrl_dec.rt = i_instr.r.rt;

        if (i_instr.r.opcode == `OP_RTYPE) begin
            // R-type view
            ctrl_dec.dest  = i_instr.r.rd;
            ctrl_dec.shamt = i_instr.r.shamt;
            ctrl_dec.valid = 1'b1;
            ctrl_dec.write = 1'b1;

            case (i_instr.r.funct)
                `FN_SLL:  ctrl_dec.alu_op = SLL;
                `FN_SRL:  ctrl_dec.alu_op = SRL;
                `FN_SRA:  ctrl_dec.alu_op = SRA;
                `FN_ADDU: ctrl_dec.alu_op = ADD;
                `FN_SUBU: ctrl_dec.alu_op = SUB;
                `FN_AND:  ctrl_dec.alu_op = AND;
                `FN_OR:   ctrl_dec.alu_op = OR;
                `FN_XOR:  ctrl_dec.alu_op = XOR;
                `FN_NOR:  ctrl_dec.alu_op = NOR;
                `FN_SLT:  ctrl_dec.alu_op = SLT;
                `FN_SLTU: ctrl_dec.alu_op = SLTU;
                default: begin
                    ctrl_dec.valid = 1'b0;  // Unknown funct
                    ctrl_dec.write = 1'b0;
                end
            endcase
        end else begin
            // I-type view, result goes to rt
            ctrl_dec.dest    = i_instr.i.rt;
            ctrl_dec.imm     = i_instr.i.imm;
            ctrl_dec.use_imm = 1'b1;
            ctrl_dec.valid   = 1'b1;
            ctrl_dec.write   = 1'b1;

            case (i_instr.i.opcode)
                `OP_ADDIU: begin
                    ctrl_dec.alu_op     = ADD;
                    ctrl_dec.imm_signed = 1'b1;
                end
                `OP_SLTI: begin
                    ctrl_dec.alu_op     = SLT;
                    ctrl_dec.imm_signed = 1'b1;
                end
                `OP_SLTIU: begin
                    ctrl_dec.alu_op     = SLTU;
                    ctrl_dec.imm_signed = 1'b1;  // Extended signed, compared unsigned
                end
                `OP_ANDI: ctrl_dec.alu_op = AND;
                `OP_ORI:  ctrl_dec.alu_op = OR;
                `OP_XORI: ctrl_dec.alu_op = XOR;
                `OP_LUI:  ctrl_dec.alu_op = LUI;
                default: begin
                    ctrl_dec.valid = 1'b0;
                    ctrl_dec.write = 1'b0;
                end
            endcase
        end
    end

    // Addresses go to the bank in the same cycle
    assign o_read_reg_a = ctrl_dec.rs;
    assign o_read_reg_b = ctrl_dec.rt;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_ctrl.valid <= 1'b0;
            o_ctrl.write <= 1'b0;
        end else if (i_instr_valid && !i_halt) begin
            o_ctrl <= ctrl_dec;
        end else begin
            o_ctrl.valid <= 1'b0;  // Bubble
            o_ctrl.write <= 1'b0;
        end
    end

endmodule

/* execute_stage.sv */
`include "core_defines.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  ctrl_t               i_ctrl,
    input  logic [`NB_DATA-1:0] i_data_a,
    input  logic [`NB_DATA-1:0] i_data_b,
    output result_t             o_result
);

    logic                fwd_a;
    logic                fwd_b;
    logic [`NB_DATA-1:0] op_a;
    logic [`NB_DATA-1:0] rt_data;
    logic [`NB_DATA-1:0] imm_ext;
    logic [`NB_DATA-1:0] op_b;
    logic [`NB_DATA-1:0] alu_value;

    // Previous instruction still in the result register, not yet in the bank
    assign fwd_a = o_result.write && (o_result.dest != '0) && (o_result.dest == i_ctrl.rs);
    assign fwd_b = o_result.write && (o_result.dest != '0) && (o_result.dest == i_ctrl.rt);

    assign op_a    = fwd_a ? o_result.value : i_data_a;
    assign rt_data = fwd_b ? o_result.value : i_data_b;

    always_comb begin
        if (i_ctrl.imm_signed) begin
            imm_ext = {{(`NB_DATA-`NB_IMM){i_ctrl.imm[`NB_IMM-1]}}, i_ctrl.imm};
        end else begin
            imm_ext = {{(`NB_DATA-`NB_IMM){1'b0}}, i_ctrl.imm};
        end
    end

    assign op_b = i_ctrl.use_imm ? imm_ext : rt_data;

    always_comb begin
        case (i_ctrl.alu_op)
            ADD:  alu_value = op_a + op_b;
            SUB:  alu_value = op_a - op_b;
            AND:  alu_value = op_a & op_b;
            OR:   alu_value = op_a | op_b;
            XOR:  alu_value = op_a ^ op_b;
            NOR:  alu_value = ~(op_a | op_b);
            SLT: begin
                alu_value = {{(`NB_DATA-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            SLTU: begin
                alu_value = {{(`NB_DATA-1){1'b0}}, (op_a < op_b)};
            end
            // Shifts operate on rt
            SLL:  alu_value = op_b << i_ctrl.shamt;
            SRL:  alu_value = op_b >> i_ctrl.shamt;
            SRA:  alu_value = $unsigned($signed(op_b) >>> i_ctrl.shamt);
            LUI:  alu_value = {i_ctrl.imm, {(`NB_DATA-`NB_IMM){1'b0}}};
            default: alu_value = '0;
        endcase
    end

    // Write-back register, read by the bank one edge later
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_result.valid <= 1'b0;
            o_result.write <= 1'b0;
        end else begin
            o_result.valid <= i_ctrl.valid;
            o_result.write <= i_ctrl.valid && i_ctrl.write;
            o_result.dest  <= i_ctrl.dest;
            o_result.value <= alu_value;
        end
    end

endmodule

/* registers_bank.sv */
`include "core_defines.svh"

module registers_bank (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_enable,        // Low while halted
    input  logic                i_reg_write,
    input  logic [`NB_ADDR-1:0] i_read_reg_a,
    input  logic [`NB_ADDR-1:0] i_read_reg_b,
    input  logic [`NB_ADDR-1:0] i_write_reg,
    input  logic [`NB_DATA-1:0] i_write_data,
    input  logic                i_read_enable,   // Debug read strobe
    input  logic [`NB_ADDR-1:0] i_read_address,  // Debug read address
    output logic [`NB_DATA-1:0] o_data_a,
    output logic [`NB_DATA-1:0] o_data_b
);

    logic [`NB_DATA-1:0] registers [`BANK_DEPTH];

    logic write_ok;
    logic bypass_a;
    logic bypass_b;

    // Register 0 is hardwired, so writes to it are dropped
    assign write_ok = i_reg_write && (i_write_reg != '0);

    // A value written this cycle is handed straight to a matching read
    assign bypass_a = write_ok && (i_write_reg == i_read_reg_a);
    assign bypass_b = write_ok && (i_write_reg == i_read_reg_b);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int idx = 0; idx < `BANK_DEPTH; idx++) begin
                registers[idx] <= '0;
            end
            o_data_a <= '0;
            o_data_b <= '0;
        end else if (i_enable) begin
            if (write_ok) begin
                registers[i_write_reg] <= i_write_data;
            end

            if (bypass_a) begin
                o_data_a <= i_write_data;
            end else begin
                o_data_a <= registers[i_read_reg_a];
            end

            if (bypass_b) begin
                o_data_b <= i_write_data;
            end else begin
                o_data_b <= registers[i_read_reg_b];
            end
        end else if (i_read_enable) begin
            // Halted, port A serves the debug read
            o_data_a <= registers[i_read_address];
        end
    end

endmodule

/* src.f */
+incdir+.
core_pkg.sv
registers_bank.sv
decode_stage.sv
execute_stage.sv
core_top.sv
tb_core.sv

/* tb_core.sv */
`include "core_defines.svh"

module tb_core
    import core_pkg::*;
();

    localparam logic [31:0] SEED        = 32'hba3f_e8cf;
    localparam int          NUM_INSTR   = 400;
    localparam int          DRAIN_LIMIT = 16;   // Cycles allowed for results to drain

    logic                clock;
    logic                reset;
    logic                instr_valid;
    instr_t              instr;
    logic                halt;
    logic                debug_read;
    logic [`NB_ADDR-1:0] debug_addr;
    result_t             result;
    logic [`NB_DATA-1:0] debug_data;

    logic [`NB_DATA-1:0] model_regs [`BANK_DEPTH];  // Reference register state
    result_t             expect_q [$];
    int                  edge_q [$];                 // Edge at which each result is due
    int                  edge_count;

    core_top dut0 (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_halt        (halt),
        .i_debug_read  (debug_read),
        .i_debug_addr  (debug_addr),
        .o_result      (result),
        .o_debug_data  (debug_data)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp_val);
        stop_run();
    endtask

    task automatic fail_words(input string text);
        $display("Error: %s", text);
        stop_run();
    endtask

    function automatic logic [`NB_ADDR-1:0] pick_reg();
        if ($urandom_range(0, 9) < 8) begin
            return $urandom_range(0, 3);  // Few registers, many hazards
        end
        return $urandom_range(0, 31);
    endfunction

    function automatic logic [5:0] pick_funct(input int sel);
        case (sel)
            0:       return `FN_SLL;
            1:       return `FN_SRL;
            2:       return `FN_SRA;
            3:       return `FN_ADDU;
            4:       return `FN_SUBU;
            5:       return `FN_AND;
            6:       return `FN_OR;
            7:       return `FN_XOR;
            8:       return `FN_NOR;
            9:       return `FN_SLT;
            default: return `FN_SLTU;
        endcase
    endfunction

    function automatic logic [5:0] pick_opcode(input int sel);
        case (sel)
            0:       return `OP_ADDIU;
            1:       return `OP_SLTI;
            2:       return `OP_SLTIU;
            3:       return `OP_ANDI;
            4:       return `OP_ORI;
            5:       return `OP_XORI;
            default: return `OP_LUI;
        endcase
    endfunction

    function automatic instr_t random_instr();
        instr_t ins;
        int     kind;
        ins      = $urandom;  // Random shamt and immediate bits
        ins.r.rs = pick_reg();
        ins.r.rt = pick_reg();
        kind     = $urandom_range(0, 19);
        if (kind < 9) begin
            ins.r.opcode = `OP_RTYPE;
            ins.r.rd     = pick_reg();
            ins.r.funct  = pick_funct($urandom_range(0, 10));
        end else if (kind < 18) begin
            ins.i.opcode = pick_opcode($urandom_range(0, 6));
        end else if (kind == 18) begin
            ins.i.opcode = 6'h04 + $urandom_range(0, 4);  // Branch and jump opcodes
        end else begin
            ins.r.opcode = `OP_RTYPE;
            ins.r.funct  = 6'h08;  // JR
        end
        return ins;
    endfunction

    function automatic instr_t make_r(input logic [5:0] funct, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] shamt);
        instr_t ins;
        ins.r = '{opcode: `OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: funct};
        return ins;
    endfunction

    function automatic instr_t make_i(input logic [5:0] opcode, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
        instr_t ins;
        ins.i = '{opcode: opcode, rs: rs, rt: rt, imm: imm};
        return ins;
    endfunction

    // One instruction executed in order against model_regs
    function automatic logic predict(input instr_t ins, output logic [`NB_ADDR-1:0] dest,
                                     output logic [`NB_DATA-1:0] value);
        logic [`NB_DATA-1:0] rs_v;
        logic [`NB_DATA-1:0] rt_v;
        logic [`NB_DATA-1:0] sext;
        logic [`NB_DATA-1:0] zext;
        logic                ok;
        rs_v  = model_regs[ins.r.rs];
        rt_v  = model_regs[ins.r.rt];
        sext  = {{16{ins.i.imm[15]}}, ins.i.imm};
        zext  = {16'h0000, ins.i.imm};
        ok    = 1'b1;
        value = '0;
        if (ins.r.opcode == `OP_RTYPE) begin
            dest = ins.r.rd;
            case (ins.r.funct)
                `FN_SLL:  value = rt_v << ins.r.shamt;
                `FN_SRL:  value = rt_v >> ins.r.shamt;
                `FN_SRA:  value = $signed(rt_v) >>> ins.r.shamt;
                `FN_ADDU: value = rs_v + rt_v;
                `FN_SUBU: value = rs_v - rt_v;
                `FN_AND:  value = rs_v & rt_v;
                `FN_OR:   value = rs_v | rt_v;
                `FN_XOR:  value = rs_v ^ rt_v;
                `FN_NOR:  value = ~(rs_v | rt_v);
                `FN_SLT:  value = {31'd0, ($signed(rs_v) < $signed(rt_v))};
                `FN_SLTU: value = {31'd0, (rs_v < rt_v)};
                default:  ok = 1'b0;
            endcase
        end else begin
            dest = ins.i.rt;
            case (ins.i.opcode)
                `OP_ADDIU: value = rs_v + sext;
                `OP_SLTI:  value = {31'd0, ($signed(rs_v) < $signed(sext))};
                `OP_SLTIU: value = {31'd0, (rs_v < sext)};  // Unsigned compare
                `OP_ANDI:  value = rs_v & zext;
                `OP_ORI:   value = rs_v | zext;
                `OP_XORI:  value = rs_v ^ zext;
                `OP_LUI:   value = {ins.i.imm, 16'h0000};
                default:   ok = 1'b0;
            endcase
        end
        return ok;
    endfunction

    task automatic issue_instr(input instr_t ins);
        logic [`NB_ADDR-1:0] dest;
        logic [`NB_DATA-1:0] value;
        result_t             exp_res;
        @(posedge clock);
        instr_valid <= 1'b1;
        instr       <= ins;
        if (predict(ins, dest, value)) begin
            exp_res.valid = 1'b1;
            exp_res.write = 1'b1;
            exp_res.dest  = dest;
            exp_res.value = value;
            expect_q.push_back(exp_res);
            edge_q.push_back(edge_count + 3);  // Sampled next edge, registered the one after
            if (dest != '0) begin
                model_regs[dest] = value;
            end
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clock);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic set_halt(input logic level);
        @(posedge clock);
        halt <= level;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        assert (expect_q.size() == 0)
            else fail_words($sformatf("%0d results missing after %0d cycles",
                                      expect_q.size(), waited));
    endtask

    task automatic debug_check(input logic [`NB_ADDR-1:0] addr, input logic [31:0] exp_val);
        @(posedge clock);
        debug_read <= 1'b1;
        debug_addr <= addr;
        @(posedge clock);
        debug_read <= 1'b0;
        @(negedge clock);
        assert (debug_data === exp_val)
            else fail_value($sformatf("o_debug_data (r%0d)", addr), debug_data, exp_val);
    endtask

    task automatic check_all_regs();
        for (int idx = 0; idx < `BANK_DEPTH; idx++) begin
            debug_check(idx[`NB_ADDR-1:0], model_regs[idx]);
        end
    endtask

    // Results compared in issue order, on the falling edge
    always @(negedge clock) begin : result_monitor
        result_t exp_res;
        int      exp_edge;
        if (!reset && result.valid) begin
            assert (expect_q.size() > 0)
                else fail_words("o_result.valid strobe with no instruction outstanding");
            exp_res  = expect_q.pop_front();
            exp_edge = edge_q.pop_front();
            assert (edge_count == exp_edge)
                else fail_value("o_result.valid edge", edge_count, exp_edge);
            assert (result.write === exp_res.write)
                else fail_value("o_result.write", result.write, exp_res.write);
            assert (result.dest === exp_res.dest)
                else fail_value("o_result.dest", result.dest, exp_res.dest);
            assert (result.value === exp_res.value)
                else fail_value("o_result.value", result.value, exp_res.value);
        end
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        halt        = 1'b0;
        debug_read  = 1'b0;
        debug_addr  = '0;
        edge_count  = 0;
        for (int idx = 0; idx < `BANK_DEPTH; idx++) begin
            model_regs[idx] = '0;
        end
        void'($urandom(SEED));

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        // Clean state out of reset
        @(negedge clock);
        assert (result.valid == 1'b0) else fail_value("o_result.valid", result.valid, 1'b0);
        idle_cycles(3);
        set_halt(1'b1);
        check_all_regs();
        set_halt(1'b0);

        // Directed chain through forwarding and the bank bypass
        issue_instr(make_i(`OP_ADDIU, 5'd0, 5'd1, 16'h8001));
        issue_instr(make_r(`FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        issue_instr(make_r(`FN_SUBU, 5'd1, 5'd2, 5'd3, 5'd0));
        issue_instr(make_r(`FN_SRA, 5'd0, 5'd3, 5'd1, 5'd4));
        issue_instr(make_i(6'h04, 5'd1, 5'd2, 16'h0010));  // BEQ, dropped
        issue_instr(make_i(`OP_SLTIU, 5'd1, 5'd2, 16'hffff));
        issue_instr(make_i(`OP_LUI, 5'd0, 5'd3, 16'hbeef));
        issue_instr(make_i(`OP_ORI, 5'd3, 5'd0, 16'h1234));  // Target is r0
        issue_instr(make_r(`FN_ADDU, 5'd0, 5'd3, 5'd1, 5'd0));
        idle_cycles(1);
        wait_drain();

        for (int n = 0; n < NUM_INSTR; n++) begin
            issue_instr(random_instr());
            idle_cycles($urandom_range(0, 3));
        end
        idle_cycles(1);
        wait_drain();

        // Halt, try to issue, then dump the bank
        idle_cycles(3);
        set_halt(1'b1);
        for (int n = 0; n < 4; n++) begin
            @(posedge clock);
            instr_valid <= 1'b1;
            instr       <= random_instr();
        end
        idle_cycles(1);
        check_all_regs();
        set_halt(1'b0);
        idle_cycles(3);
        wait_drain();

        $display("Verification passed");
        $finish;
    end

endmodule
